//--- Bender.yml
package:
  name: decode_unit

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/rv_isa_pkg.sv
      - hw/uop_pkg.sv
      - hw/uop_if.sv
      - hw/instr_decoder.sv
      - hw/uop_fifo.sv
      - hw/operand_issue.sv
      - hw/decode_unit.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - dv/decode_unit_tb.sv

//--- dv/decode_unit_tb.sv
`timescale 1ns/10ps
`include "rv_consts.svh"

module decode_unit_tb import rv_isa_pkg::*, uop_pkg::*; ();

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 4;
    localparam int SEED         = 32'h54ab;
    localparam logic [`XLEN-1:0] RF_BASE = 64'h5a5a_c3c3_0f0f_9696;

    // expected flag bits are packed as {load, store, imm, word, unsigned, wb, illegal}.
    localparam logic [6:0] F_LOAD  = 7'h40;
    localparam logic [6:0] F_STORE = 7'h20;
    localparam logic [6:0] F_IMM   = 7'h10;
    localparam logic [6:0] F_WORD  = 7'h08;
    localparam logic [6:0] F_UNS   = 7'h04;
    localparam logic [6:0] F_WB    = 7'h02;
    localparam logic [6:0] F_ILL   = 7'h01;

    typedef struct packed {
        logic [`INSTR_WIDTH-1:0]    instr;
        logic [`PC_WIDTH-1:0]       pc;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [`REG_ADDR_WIDTH-1:0] rs1;
        logic [`REG_ADDR_WIDTH-1:0] rs2;
        logic [`XLEN-1:0]           imm;
        alu_op_e                    alu_op;
        cx_op_e                     cx_op;
        ls_size_e                   ls_size;
        logic [6:0]                 flags;
    } entry_t;

    logic                       clock;
    logic                       reset;
    logic                       in_valid;
    logic                       in_ready;
    logic [`INSTR_WIDTH-1:0]    in_instr;
    logic [`PC_WIDTH-1:0]       in_pc;
    logic [`REG_ADDR_WIDTH-1:0] rs1_addr;
    logic [`REG_ADDR_WIDTH-1:0] rs2_addr;
    logic [`XLEN-1:0]           rs1_data;
    logic [`XLEN-1:0]           rs2_data;
    logic                       out_valid;
    logic                       out_ready = 1'b1;
    logic [`PC_WIDTH-1:0]       out_pc;
    logic [`REG_ADDR_WIDTH-1:0] out_rd;
    logic [`XLEN-1:0]           out_src1;
    logic [`XLEN-1:0]           out_src2;
    logic [`XLEN-1:0]           out_imm;
    alu_op_e                    out_alu_op;
    cx_op_e                     out_cx_op;
    ls_size_e                   out_ls_size;
    logic                       out_is_load;
    logic                       out_is_store;
    logic                       out_is_word;
    logic                       out_is_unsigned;
    logic                       out_need_wb;
    logic                       out_illegal;

    entry_t tbl[$];
    logic   table_ready = 1'b0;
    int     cycle = 0;
    int     in_count = 0;
    int     out_count = 0;
    int     first_in_edge = -1;
    int     field_errors = 0;
    int     flow_errors = 0;

    decode_unit i_dut (.*);

    // every register address reads back a distinct value.
    function automatic logic [`XLEN-1:0] rf_value(input logic [`REG_ADDR_WIDTH-1:0] addr);
        return RF_BASE ^ {8{3'b000, addr}};
    endfunction

    assign rs1_data = rf_value(rs1_addr);
    assign rs2_data = rf_value(rs2_addr);

    // ----------------------------------------
    // instruction encoders
    // ----------------------------------------
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    // ----------------------------------------
    // expected operands
    // ----------------------------------------
    function automatic bit uses_rs1(input entry_t e);
        return !(e.alu_op == ALU_AUIPC || e.alu_op == ALU_LUI || e.cx_op == CX_JAL);
    endfunction

    function automatic bit uses_rs2(input entry_t e);
        return !((e.flags & (F_IMM | F_LOAD)) != 0 || e.alu_op == ALU_LUI ||
                 e.alu_op == ALU_AUIPC);
    endfunction

    function automatic logic [`XLEN-1:0] expected_src1(input entry_t e);
        if (e.alu_op == ALU_LUI) return '0;
        if (!uses_rs1(e)) return {{(`XLEN-`PC_WIDTH){1'b0}}, e.pc}; // pc is zero-extended.
        return rf_value(e.rs1);
    endfunction

    function automatic logic [`XLEN-1:0] expected_src2(input entry_t e);
        return uses_rs2(e) ? rf_value(e.rs2) : e.imm;
    endfunction

    task automatic add_entry(input logic [31:0] instr, input logic [4:0] rd,
                             input logic [4:0] rs1, input logic [4:0] rs2,
                             input logic [63:0] imm, input alu_op_e alu, input cx_op_e cx,
                             input ls_size_e ls, input logic [6:0] flags);
        entry_t e;
        e.instr   = instr;
        e.pc      = 48'h8765_4321_0000 + 48'(4 * tbl.size()); // bit 47 set on purpose.
        e.rd      = rd;
        e.rs1     = rs1;
        e.rs2     = rs2;
        e.imm     = imm;
        e.alu_op  = alu;
        e.cx_op   = cx;
        e.ls_size = ls;
        e.flags   = flags;
        tbl.push_back(e);
    endtask

    task automatic build_table();
        // alu register and immediate forms.
        add_entry(enc_r(32, 3, 2, 0, 1, OPC_OP), 1, 2, 3,
                  0, ALU_SUB, CX_NONE, LS_NONE, F_WB);
        add_entry(enc_r(0, 6, 5, 0, 4, OPC_OP), 4, 5, 6,
                  0, ALU_ADD, CX_NONE, LS_NONE, F_WB);
        add_entry(enc_r(32, 9, 8, 5, 7, OPC_OP), 7, 8, 9,
                  0, ALU_SRA, CX_NONE, LS_NONE, F_WB);
        add_entry(enc_r(0, 12, 11, 3, 10, OPC_OP), 10, 11, 12,
                  0, ALU_SLT, CX_NONE, LS_NONE, F_WB | F_UNS);
        add_entry(enc_r(0, 15, 14, 4, 13, OPC_OP), 13, 14, 15,
                  0, ALU_XOR, CX_NONE, LS_NONE, F_WB);
        add_entry(enc_i(12'hfff, 2, 0, 1, OPC_OP_IMM), 1, 2, 0,
                  -1, ALU_ADD, CX_NONE, LS_NONE, F_WB | F_IMM);
        add_entry(enc_i(12'h43f, 4, 5, 3, OPC_OP_IMM), 3, 4, 0,
                  'h43f, ALU_SRA, CX_NONE, LS_NONE, F_WB | F_IMM);
        add_entry(enc_i(12'h7ff, 6, 3, 5, OPC_OP_IMM), 5, 6, 0,
                  2047, ALU_SLT, CX_NONE, LS_NONE, F_WB | F_IMM | F_UNS);
        add_entry(enc_i(12'h021, 8, 1, 7, OPC_OP_IMM), 7, 8, 0,
                  33, ALU_SLL, CX_NONE, LS_NONE, F_WB | F_IMM);
        add_entry(enc_i(12'h800, 10, 0, 9, OPC_OP_IMM_32), 9, 10, 0,
                  -2048, ALU_ADD, CX_NONE, LS_NONE, F_WB | F_IMM | F_WORD);
        add_entry(enc_r(32, 13, 12, 0, 11, OPC_OP_32), 11, 12, 13,
                  0, ALU_SUB, CX_NONE, LS_NONE, F_WB | F_WORD);
        add_entry(enc_i(12'h41f, 15, 5, 14, OPC_OP_IMM_32), 14, 15, 0,
                  'h41f, ALU_SRA, CX_NONE, LS_NONE, F_WB | F_IMM | F_WORD);
        // upper immediates and jumps.
        add_entry(enc_u(20'h80001, 20, OPC_LUI), 20, 0, 0,
                  64'hffff_ffff_8000_1000, ALU_LUI, CX_NONE, LS_NONE, F_WB);
        add_entry(enc_u(20'h12345, 21, OPC_AUIPC), 21, 0, 0,
                  'h1234_5000, ALU_AUIPC, CX_NONE, LS_NONE, F_WB);
        add_entry(enc_j(21'h1ffffc, 1), 1, 0, 29,
                  -4, ALU_NONE, CX_JAL, LS_NONE, F_WB);
        add_entry(enc_i(12'h010, 5, 0, 1, OPC_JALR), 1, 5, 16,
                  16, ALU_NONE, CX_JALR, LS_NONE, F_WB);
        // branches.
        add_entry(enc_b(13'h0008, 2, 1, 0), 0, 1, 2, 8, ALU_NONE, CX_BEQ, LS_NONE, 0);
        add_entry(enc_b(13'h1ff0, 4, 3, 1), 0, 3, 4, -16, ALU_NONE, CX_BNE, LS_NONE, 0);
        add_entry(enc_b(13'h0ffe, 6, 5, 4), 0, 5, 6, 4094, ALU_NONE, CX_BLT, LS_NONE, 0);
        add_entry(enc_b(13'h1000, 8, 7, 5), 0, 7, 8, -4096, ALU_NONE, CX_BGE, LS_NONE, 0);
        add_entry(enc_b(13'h0800, 10, 9, 6), 0, 9, 10,
                  2048, ALU_NONE, CX_BLT, LS_NONE, F_UNS);
        add_entry(enc_b(13'h002a, 12, 11, 7), 0, 11, 12,
                  42, ALU_NONE, CX_BGE, LS_NONE, F_UNS);
        // loads and stores.
        add_entry(enc_i(12'hfff, 2, 0, 1, OPC_LOAD), 1, 2, 0,
                  -1, ALU_NONE, CX_NONE, LS_BYTE, F_LOAD | F_WB);
        add_entry(enc_i(12'h006, 4, 5, 3, OPC_LOAD), 3, 4, 0,
                  6, ALU_NONE, CX_NONE, LS_HALF, F_LOAD | F_WB | F_UNS);
        add_entry(enc_i(12'h7ff, 6, 6, 5, OPC_LOAD), 5, 6, 0,
                  2047, ALU_NONE, CX_NONE, LS_WORD, F_LOAD | F_WB | F_UNS);
        add_entry(enc_i(12'hff8, 8, 3, 7, OPC_LOAD), 7, 8, 0,
                  -8, ALU_NONE, CX_NONE, LS_DOUBLE, F_LOAD | F_WB);
        add_entry(enc_s(12'h005, 9, 10, 0), 0, 10, 9, 5, ALU_NONE, CX_NONE, LS_BYTE, F_STORE);
        add_entry(enc_s(12'hffe, 11, 12, 1), 0, 12, 11,
                  -2, ALU_NONE, CX_NONE, LS_HALF, F_STORE);
        add_entry(enc_s(12'h7f8, 13, 14, 3), 0, 14, 13,
                  2040, ALU_NONE, CX_NONE, LS_DOUBLE, F_STORE);
        // mul, fence, ecall and a custom opcode are all outside the decoder.
        add_entry(enc_r(1, 3, 2, 0, 1, OPC_OP), 0, 2, 3, 0, ALU_NONE, CX_NONE, LS_NONE, F_ILL);
        add_entry(enc_i(12'h0ff, 0, 0, 0, 7'b0001111), 0, 0, 31,
                  0, ALU_NONE, CX_NONE, LS_NONE, F_ILL);
        add_entry(32'h0000_0073, 0, 0, 0, 0, ALU_NONE, CX_NONE, LS_NONE, F_ILL);
        add_entry(enc_r(0, 7, 6, 0, 5, 7'h7f), 0, 6, 7, 0, ALU_NONE, CX_NONE, LS_NONE, F_ILL);
    endtask

    // ----------------------------------------
    // scoreboard
    // ----------------------------------------
    task automatic check_field(input int idx, input string name,
                               input logic [63:0] got, input logic [63:0] want);
        assert (got === want) else begin
            $display("ERROR %0t: uop %0d %s is %h, expected %h", $time, idx, name, got, want);
            field_errors++;
        end
    endtask

    task automatic check_uop(input int idx);
        entry_t     e;
        logic [6:0] got_flags;
        e = tbl[idx];
        got_flags = {out_is_load, out_is_store, 1'b0, out_is_word, out_is_unsigned,
                     out_need_wb, out_illegal};
        check_field(idx, "pc", out_pc, e.pc);
        if ((e.flags & F_WB) != 0) check_field(idx, "rd", out_rd, e.rd);
        if (uses_rs1(e)) check_field(idx, "rs1_addr", rs1_addr, e.rs1);
        if (uses_rs2(e)) check_field(idx, "rs2_addr", rs2_addr, e.rs2);
        check_field(idx, "src1", out_src1, expected_src1(e));
        check_field(idx, "src2", out_src2, expected_src2(e));
        check_field(idx, "imm", out_imm, e.imm);
        check_field(idx, "alu_op", out_alu_op, e.alu_op);
        check_field(idx, "cx_op", out_cx_op, e.cx_op);
        check_field(idx, "ls_size", out_ls_size, e.ls_size);
        check_field(idx, "flags", got_flags, e.flags & ~F_IMM); // is_imm has no port.
    endtask

    task automatic report_counts();
        $display("errors: %0d field, %0d flow; %0d of %0d micro-ops received",
                 field_errors, flow_errors, out_count, tbl.size());
    endtask

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    always @(posedge clock) cycle <= cycle + 1;

    // random stalls start once the first micro-op has left.
    initial begin
        void'($urandom(SEED));
        forever begin
            @(posedge clock);
            if (reset || out_count == 0) out_ready <= 1'b1;
            else out_ready <= ($urandom % 4) < 2;
        end
    end

    // handshakes are looked at mid-cycle, ahead of the edge that completes them.
    always @(negedge clock) begin
        if (!reset && in_valid && in_ready) begin
            if (in_count == 0) first_in_edge = cycle + 1;
            in_count++;
        end
        if (!reset && out_valid && out_ready) begin
            assert (out_count < tbl.size()) else begin
                $display("unexpected extra micro-op with pc %h after the last one", out_pc);
                flow_errors++;
            end
            if (out_count < tbl.size()) check_uop(out_count);
            if (out_count == 0) begin
                assert (cycle + 1 - first_in_edge == 2) else begin
                    $display("ERROR %0t: first micro-op took %0d cycles, expected 2",
                             $time, cycle + 1 - first_in_edge);
                    flow_errors++;
                end
            end
            out_count++;
        end
    end

    initial begin
        wait (table_ready);
        repeat (RESET_CYCLES + 20 * tbl.size()) @(posedge clock);
        $display("watchdog expired: the micro-op stream did not complete in time");
        report_counts();
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        reset    <= 1'b1;
        in_valid <= 1'b0;
        in_instr <= '0;
        in_pc    <= '0;
        build_table();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        assert (!out_valid && in_ready) else begin
            $display("ERROR %0t: after reset out_valid is %b and in_ready is %b",
                     $time, out_valid, in_ready);
            flow_errors++;
        end
        @(posedge clock);
        for (int i = 0; i < tbl.size(); i++) begin
            in_valid <= 1'b1;
            in_instr <= tbl[i].instr;
            in_pc    <= tbl[i].pc;
            @(negedge clock);
            while (!in_ready) @(negedge clock);
            @(posedge clock);
        end
        in_valid <= 1'b0;
        wait (out_count == tbl.size());
        repeat (10) @(posedge clock); // room for a duplicate to show up.
        report_counts();
        if (field_errors == 0 && flow_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- flist.f
+incdir+include
hw/rv_isa_pkg.sv
hw/uop_pkg.sv
hw/uop_if.sv
hw/instr_decoder.sv
hw/uop_fifo.sv
hw/operand_issue.sv
hw/decode_unit.sv
dv/decode_unit_tb.sv

//--- hw/decode_unit.sv
`timescale 1ns/10ps
`include "rv_consts.svh"

module decode_unit import uop_pkg::*; (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       in_valid,
    output logic                       in_ready,
    input  logic [`INSTR_WIDTH-1:0]    in_instr,
    input  logic [`PC_WIDTH-1:0]       in_pc,
    output logic [`REG_ADDR_WIDTH-1:0] rs1_addr,
    output logic [`REG_ADDR_WIDTH-1:0] rs2_addr,
    input  logic [`XLEN-1:0]           rs1_data,
    input  logic [`XLEN-1:0]           rs2_data,
    output logic                       out_valid,
    input  logic                       out_ready,
    output logic [`PC_WIDTH-1:0]       out_pc,
    output logic [`REG_ADDR_WIDTH-1:0] out_rd,
    output logic [`XLEN-1:0]           out_src1,
    output logic [`XLEN-1:0]           out_src2,
    output logic [`XLEN-1:0]           out_imm,
    output alu_op_e                    out_alu_op,
    output cx_op_e                     out_cx_op,
    output ls_size_e                   out_ls_size,
    output logic                       out_is_load,
    output logic                       out_is_store,
    output logic                       out_is_word,
    output logic                       out_is_unsigned,
    output logic                       out_need_wb,
    output logic                       out_illegal
);

    uop_if dec_to_fifo ();
    uop_if fifo_to_issue ();

    instr_decoder i_decoder (
        .clock    (clock),
        .reset    (reset),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .in_instr (in_instr),
        .in_pc    (in_pc),
        .uop_out  (dec_to_fifo.source)
    );

    uop_fifo #(
        .DEPTH (`UOP_FIFO_DEPTH)
    ) i_fifo (
        .clock (clock),
        .reset (reset),
        .wr    (dec_to_fifo.sink),
        .rd    (fifo_to_issue.source)
    );

    operand_issue i_issue (
        .head            (fifo_to_issue.sink),
        .rs1_addr        (rs1_addr),
        .rs2_addr        (rs2_addr),
        .rs1_data        (rs1_data),
        .rs2_data        (rs2_data),
        .out_valid       (out_valid),
        .out_ready       (out_ready),
        .out_pc          (out_pc),
        .out_rd          (out_rd),
        .out_src1        (out_src1),
        .out_src2        (out_src2),
        .out_imm         (out_imm),
        .out_alu_op      (out_alu_op),
        .out_cx_op       (out_cx_op),
        .out_ls_size     (out_ls_size),
        .out_is_load     (out_is_load),
        .out_is_store    (out_is_store),
        .out_is_word     (out_is_word),
        .out_is_unsigned (out_is_unsigned),
        .out_need_wb     (out_need_wb),
        .out_illegal     (out_illegal)
    );

endmodule

//--- hw/instr_decoder.sv
`timescale 1ns/10ps
`include "rv_consts.svh"

module instr_decoder import rv_isa_pkg::*, uop_pkg::*; (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    in_valid,
    output logic                    in_ready,
    input  logic [`INSTR_WIDTH-1:0] in_instr,
    input  logic [`PC_WIDTH-1:0]    in_pc,
    uop_if.source                   uop_out
);

    opcode_e    opcode;
    branch_f3_e br_f3;
    mem_f3_e    mem_f3;
    alu_f3_e    alu_f3;
    logic [6:0] funct7;

    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_s;
    logic [`XLEN-1:0] imm_b;
    logic [`XLEN-1:0] imm_u;
    logic [`XLEN-1:0] imm_j;

    logic is_imm;
    logic is_word;
    logic f7_std;
    logic f7_alt;

    uop_t dec;
    uop_t uop_q;
    logic valid_q;

    assign opcode = opcode_e'(in_instr[6:0]);
    assign br_f3  = branch_f3_e'(in_instr[14:12]);
    assign mem_f3 = mem_f3_e'(in_instr[14:12]);
    assign alu_f3 = alu_f3_e'(in_instr[14:12]);
    assign funct7 = in_instr[31:25];

    // ----------------------------------------
    // immediates, all sign-extended from bit 31
    // ----------------------------------------
    assign imm_i = {{(`XLEN-12){in_instr[31]}}, in_instr[31:20]};
    assign imm_s = {{(`XLEN-12){in_instr[31]}}, in_instr[31:25], in_instr[11:7]};
    assign imm_b = {{(`XLEN-13){in_instr[31]}}, in_instr[31], in_instr[7],
                    in_instr[30:25], in_instr[11:8], 1'b0};
    assign imm_u = {{(`XLEN-32){in_instr[31]}}, in_instr[31:12], 12'b0};
    assign imm_j = {{(`XLEN-21){in_instr[31]}}, in_instr[31], in_instr[19:12],
                    in_instr[20], in_instr[30:21], 1'b0};

    assign is_imm  = (opcode == OPC_OP_IMM) || (opcode == OPC_OP_IMM_32);
    assign is_word = (opcode == OPC_OP_IMM_32) || (opcode == OPC_OP_32);

    // rv64 immediate shifts carry a 6-bit shamt, so funct7[0] is shamt[5] there.
    assign f7_std = (is_imm && !is_word) ? (funct7[6:1] == 6'b000000) : (funct7 == 7'b0000000);
    assign f7_alt = (is_imm && !is_word) ? (funct7[6:1] == 6'b010000) : (funct7 == 7'b0100000);

    // ----------------------------------------
    // opcode decode
    // ----------------------------------------
    always_comb begin
        dec     = '0;
        dec.pc  = in_pc;
        dec.rd  = in_instr[11:7];
        dec.rs1 = in_instr[19:15];
        dec.rs2 = in_instr[24:20];
        case (opcode)
            OPC_LUI, OPC_AUIPC: begin
                dec.imm     = imm_u;
                dec.alu_op  = (opcode == OPC_LUI) ? ALU_LUI : ALU_AUIPC;
                dec.need_wb = 1'b1;
            end
            OPC_JAL: begin
                dec.imm     = imm_j;
                dec.cx_op   = CX_JAL;
                dec.need_wb = 1'b1;
            end
            OPC_JALR: begin
                dec.imm     = imm_i;
                dec.cx_op   = CX_JALR;
                dec.need_wb = 1'b1;
                dec.illegal = (in_instr[14:12] != 3'b000);
            end
            OPC_BRANCH: begin
                dec.imm         = imm_b;
                dec.is_unsigned = (br_f3 == BR_BLTU) || (br_f3 == BR_BGEU);
                case (br_f3)
                    BR_BEQ:           dec.cx_op = CX_BEQ;
                    BR_BNE:           dec.cx_op = CX_BNE;
                    BR_BLT, BR_BLTU:  dec.cx_op = CX_BLT;
                    BR_BGE, BR_BGEU:  dec.cx_op = CX_BGE;
                    default:          dec.illegal = 1'b1;
                endcase
            end
            OPC_LOAD, OPC_STORE: begin
                dec.is_load     = (opcode == OPC_LOAD);
                dec.is_store    = (opcode == OPC_STORE);
                dec.need_wb     = (opcode == OPC_LOAD);
                dec.imm         = (opcode == OPC_LOAD) ? imm_i : imm_s;
                dec.is_unsigned = in_instr[14]; // bu, hu and wu.
                case (mem_f3)
                    MEM_B, MEM_BU:  dec.ls_size = LS_BYTE;
                    MEM_H, MEM_HU:  dec.ls_size = LS_HALF;
                    MEM_W, MEM_WU:  dec.ls_size = LS_WORD;
                    MEM_D:          dec.ls_size = LS_DOUBLE;
                    default:        dec.illegal = 1'b1;
                endcase
                if (opcode == OPC_STORE && in_instr[14]) begin
                    dec.illegal = 1'b1; // stores have no unsigned forms.
                end
            end
            OPC_OP_IMM, OPC_OP_32, OPC_OP, OPC_OP_IMM_32: begin
                dec.imm     = is_imm ? imm_i : '0;
                dec.is_imm  = is_imm;
                dec.is_word = is_word;
                dec.need_wb = 1'b1;
                case (alu_f3)
                    F3_ADD: begin
                        if (is_imm || f7_std) dec.alu_op = ALU_ADD;
                        else if (f7_alt)      dec.alu_op = ALU_SUB;
                        else                  dec.illegal = 1'b1;
                    end
                    F3_SLL: begin
                        if (f7_std) dec.alu_op = ALU_SLL;
                        else        dec.illegal = 1'b1;
                    end
                    F3_SR: begin
                        if (f7_std)      dec.alu_op = ALU_SRL;
                        else if (f7_alt) dec.alu_op = ALU_SRA;
                        else             dec.illegal = 1'b1;
                    end
                    default: begin
                        // slt, sltu and the logic ops have no word form.
                        dec.illegal     = is_word || !(is_imm || f7_std);
                        dec.is_unsigned = (alu_f3 == F3_SLTU);
                        case (alu_f3)
                            F3_XOR:  dec.alu_op = ALU_XOR;
                            F3_OR:   dec.alu_op = ALU_OR;
                            F3_AND:  dec.alu_op = ALU_AND;
                            default: dec.alu_op = ALU_SLT;
                        endcase
                    end
                endcase
            end
            default: dec.illegal = 1'b1; // includes fence, system and custom space.
        endcase

        if (dec.illegal) begin
            dec.imm         = '0;
            dec.alu_op      = ALU_NONE;
            dec.cx_op       = CX_NONE;
            dec.ls_size     = LS_NONE;
            dec.is_load     = 1'b0;
            dec.is_store    = 1'b0;
            dec.is_imm      = 1'b0;
            dec.is_word     = 1'b0;
            dec.is_unsigned = 1'b0;
            dec.need_wb     = 1'b0;
        end
    end

    // ----------------------------------------
    // output register
    // ----------------------------------------
    assign in_ready      = !valid_q || uop_out.ready;
    assign uop_out.valid = valid_q;
    assign uop_out.uop   = uop_q;

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (in_valid && in_ready) begin
            valid_q <= 1'b1;
        end else if (uop_out.ready) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (in_valid && in_ready) begin
            uop_q <= dec;
        end
    end

endmodule

//--- hw/operand_issue.sv
`timescale 1ns/10ps
`include "rv_consts.svh"

module operand_issue import uop_pkg::*; (
    uop_if.sink                        head,
    output logic [`REG_ADDR_WIDTH-1:0] rs1_addr,
    output logic [`REG_ADDR_WIDTH-1:0] rs2_addr,
    input  logic [`XLEN-1:0]           rs1_data,
    input  logic [`XLEN-1:0]           rs2_data,
    output logic                       out_valid,
    input  logic                       out_ready,
    output logic [`PC_WIDTH-1:0]       out_pc,
    output logic [`REG_ADDR_WIDTH-1:0] out_rd,
    output logic [`XLEN-1:0]           out_src1,
    output logic [`XLEN-1:0]           out_src2,
    output logic [`XLEN-1:0]           out_imm,
    output alu_op_e                    out_alu_op,
    output cx_op_e                     out_cx_op,
    output ls_size_e                   out_ls_size,
    output logic                       out_is_load,
    output logic                       out_is_store,
    output logic                       out_is_word,
    output logic                       out_is_unsigned,
    output logic                       out_need_wb,
    output logic                       out_illegal
);

    logic src1_is_pc;
    logic src2_is_imm;

    assign out_valid  = head.valid;
    assign head.ready = out_ready;

    // the register file answers in the same cycle.
    assign rs1_addr = head.uop.rs1;
    assign rs2_addr = head.uop.rs2;

    assign src1_is_pc  = (head.uop.alu_op == ALU_AUIPC) || (head.uop.cx_op == CX_JAL);
    assign src2_is_imm = head.uop.is_imm || head.uop.is_load ||
                         (head.uop.alu_op == ALU_LUI) || (head.uop.alu_op == ALU_AUIPC);

    always_comb begin
        if (src1_is_pc) begin
            out_src1 = {{(`XLEN-`PC_WIDTH){1'b0}}, head.uop.pc};
        end else if (head.uop.alu_op == ALU_LUI) begin
            out_src1 = '0;
        end else begin
            out_src1 = rs1_data;
        end
    end

    assign out_src2 = src2_is_imm ? head.uop.imm : rs2_data; // stores keep rs2 as data.

    assign out_pc          = head.uop.pc;
    assign out_rd          = head.uop.rd;
    assign out_imm         = head.uop.imm;
    assign out_alu_op      = head.uop.alu_op;
    assign out_cx_op       = head.uop.cx_op;
    assign out_ls_size     = head.uop.ls_size;
    assign out_is_load     = head.uop.is_load;
    assign out_is_store    = head.uop.is_store;
    assign out_is_word     = head.uop.is_word;
    assign out_is_unsigned = head.uop.is_unsigned;
    assign out_need_wb     = head.uop.need_wb;
    assign out_illegal     = head.uop.illegal;

endmodule

//--- hw/rv_isa_pkg.sv
package rv_isa_pkg;

    // major opcodes, instr[6:0].
    typedef enum logic [6:0] {
        OPC_LUI       = 7'b0110111,
        OPC_AUIPC     = 7'b0010111,
        OPC_JAL       = 7'b1101111,
        OPC_JALR      = 7'b1100111,
        OPC_BRANCH    = 7'b1100011,
        OPC_LOAD      = 7'b0000011,
        OPC_STORE     = 7'b0100011,
        OPC_OP_IMM    = 7'b0010011,
        OPC_OP        = 7'b0110011,
        OPC_OP_IMM_32 = 7'b0011011,
        OPC_OP_32     = 7'b0111011
    } opcode_e;

    typedef enum logic [2:0] {
        BR_BEQ  = 3'b000,
        BR_BNE  = 3'b001,
        BR_BLT  = 3'b100,
        BR_BGE  = 3'b101,
        BR_BLTU = 3'b110,
        BR_BGEU = 3'b111
    } branch_f3_e;

    // shared by loads and stores; the unsigned forms are loads only.
    typedef enum logic [2:0] {
        MEM_B  = 3'b000,
        MEM_H  = 3'b001,
        MEM_W  = 3'b010,
        MEM_D  = 3'b011,
        MEM_BU = 3'b100,
        MEM_HU = 3'b101,
        MEM_WU = 3'b110
    } mem_f3_e;

    typedef enum logic [2:0] {
        F3_ADD  = 3'b000, // add and sub share this code.
        F3_SLL  = 3'b001,
        F3_SLT  = 3'b010,
        F3_SLTU = 3'b011,
        F3_XOR  = 3'b100,
        F3_SR   = 3'b101, // srl and sra, split by funct7.
        F3_OR   = 3'b110,
        F3_AND  = 3'b111
    } alu_f3_e;

endpackage

//--- hw/uop_fifo.sv
`timescale 1ns/10ps
`include "rv_consts.svh"

module uop_fifo import uop_pkg::*; #(
    parameter int DEPTH = `UOP_FIFO_DEPTH
) (
    input logic   clock,
    input logic   reset,
    uop_if.sink   wr,
    uop_if.source rd
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
    localparam logic [PTR_W:0] FULL_COUNT = (PTR_W + 1)'(DEPTH);

    uop_t             mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             push;
    logic             pop;

    assign wr.ready = (count != FULL_COUNT);
    assign rd.valid = (count != '0);
    assign rd.uop   = mem[rd_ptr];

    assign push = wr.valid && wr.ready;
    assign pop  = rd.valid && rd.ready;

    always_ff @(posedge clock) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // idle, or one in and one out.
            endcase
        end
    end

    // a new entry only shows at the head once count has moved.
    always_ff @(posedge clock) begin
        if (push) begin
            mem[wr_ptr] <= wr.uop;
        end
    end

endmodule

//--- hw/uop_if.sv
`timescale 1ns/10ps

// one micro-op moves on a clock edge where valid and ready are both high.
interface uop_if import uop_pkg::*; ();

    logic valid;
    logic ready;
    uop_t uop;

    modport source (
        output valid,
        output uop,
        input  ready
    );

    modport sink (
        input  valid,
        input  uop,
        output ready
    );

endinterface

//--- hw/uop_pkg.sv
package uop_pkg;

    `include "rv_consts.svh"

    typedef enum logic [3:0] {
        ALU_NONE,
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT, // also sltu, with is_unsigned.
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_LUI,
        ALU_AUIPC
    } alu_op_e;

    // control transfer; bltu and bgeu reuse blt and bge with is_unsigned.
    typedef enum logic [2:0] {
        CX_NONE,
        CX_JAL,
        CX_JALR,
        CX_BEQ,
        CX_BNE,
        CX_BLT,
        CX_BGE
    } cx_op_e;

    typedef enum logic [2:0] {
        LS_NONE,
        LS_BYTE,
        LS_HALF,
        LS_WORD,
        LS_DOUBLE
    } ls_size_e;

    typedef struct packed {
        logic [`PC_WIDTH-1:0]       pc;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [`REG_ADDR_WIDTH-1:0] rs1;
        logic [`REG_ADDR_WIDTH-1:0] rs2;
        logic [`XLEN-1:0]           imm;
        alu_op_e                    alu_op;
        cx_op_e                     cx_op;
        ls_size_e                   ls_size;
        logic                       is_load;
        logic                       is_store;
        logic                       is_imm;
        logic                       is_word;
        logic                       is_unsigned;
        logic                       need_wb;
        logic                       illegal;
    } uop_t;

endpackage

//--- include/rv_consts.svh
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// ----------------------------------------
// datapath widths
// ----------------------------------------

`define XLEN 64 // integer register width for rv64i.

`define PC_WIDTH 48

`define INSTR_WIDTH 32

`define REG_ADDR_WIDTH 5

// ----------------------------------------
// buffering
// ----------------------------------------

// number of micro-op entries between decode and issue.
`define UOP_FIFO_DEPTH 4

`endif
